// ==== src/doodlePkg.sv ====
// ------------------------------------------------------------
// screen coordinates are 10 bits and platform coordinates 9 bits
// platform Y wraps modulo 512; colour triples are ordered R, G, B
// ------------------------------------------------------------
package doodlePkg;

    typedef logic [9:0] coordT;
    typedef logic [8:0] platCoordT;
    typedef logic [7:0] colorT;

    typedef enum logic [1:0]
    {
        MENU  = 2'd0,
        GAME  = 2'd1,
        PAUSE = 2'd2
    } gameStateT;

    // code 3 is decoded as HARD
    typedef enum logic [1:0]
    {
        EASY   = 2'd0,
        MEDIUM = 2'd1,
        HARD   = 2'd2
    } difficultyT;

    // ------------------------------------------------------------
    // field layout
    localparam int NUM_PLATS = 8;
    localparam int NUM_CANNONS = 3;
    localparam platCoordT PLAT_Y_STEP = 9'd30;
    localparam platCoordT PLAT_X_RESET = 9'd240;
    localparam platCoordT PLACE_LIMIT = 9'd400;
    localparam platCoordT PLACE_OFFSET = 9'd100;
    localparam platCoordT RNG_SEED = 9'h1A5;

    // box sizes and menu bar centres
    localparam coordT PLAT_HALF_EASY = 10'd32;
    localparam coordT PLAT_HALF_MEDIUM = 10'd16;
    localparam coordT PLAT_HALF_HARD = 10'd8;
    localparam coordT PLAT_HALF_H = 10'd4;
    localparam coordT MENU_BAR_Y = 10'd200;
    localparam coordT MENU_BAR_X_EASY = 10'd230;
    localparam coordT MENU_BAR_X_MEDIUM = 10'd330;
    localparam coordT MENU_BAR_X_HARD = 10'd430;

    // ------------------------------------------------------------
    // colours
    localparam colorT COL_DOODLE [3] = '{8'hA5, 8'hA5, 8'h25};
    localparam colorT COL_EASY [3] = '{8'h00, 8'h00, 8'hFF};
    localparam colorT COL_MEDIUM [3] = '{8'h00, 8'hFF, 8'h00};
    localparam colorT COL_HARD [3] = '{8'hFF, 8'h00, 8'h00};
    localparam colorT COL_PLAT [3] = '{8'h66, 8'hDD, 8'h11};
    localparam colorT COL_CANNON0 [3] = '{8'hFF, 8'h00, 8'h00};
    localparam colorT COL_CANNON1 [3] = '{8'hFF, 8'h33, 8'h33};
    localparam colorT COL_CANNON2 [3] = '{8'hFF, 8'h66, 8'h66};
    localparam colorT COL_MENU_BG [3] = '{8'h00, 8'h00, 8'h00};
    localparam colorT COL_GAME_BG [3] = '{8'hEE, 8'hEE, 8'hEE};

endpackage

// ==== src/platformRng.sv ====
// ------------------------------------------------------------
// steps once per frame in every state; period is 511 frames
// ------------------------------------------------------------
module platformRng
(
    input  logic                 frame_clk,
    input  logic                 loadplat,
    output doodlePkg::platCoordT rawX
);
    import doodlePkg::*;

    platCoordT lfsrState;

    // fibonacci form of x^9 + x^5 + 1
    always_ff @(posedge frame_clk or posedge loadplat)
    begin
        if (loadplat)
        begin
            lfsrState <= RNG_SEED;
        end
        else
        begin
            lfsrState <= {lfsrState[7:0], lfsrState[8] ^ lfsrState[4]};
        end
    end

    assign rawX = lfsrState;

    // the all-zero state would lock the generator up
    stateNonZero: assert property (
        @(posedge frame_clk) disable iff (loadplat)
        lfsrState != '0
    ) else $error("platform generator reached the zero state");

endmodule

// ==== src/platformField.sv ====
// ------------------------------------------------------------
// positions update one frame_clk edge after gameState is sampled
// code 3 of gameState holds like PAUSE
// ------------------------------------------------------------
module platformField
(
    input  logic                 frame_clk,
    input  logic                 loadplat,
    input  doodlePkg::gameStateT gameState,
    input  doodlePkg::platCoordT scrollY,
    input  doodlePkg::platCoordT rawX,
    output doodlePkg::platCoordT platX [doodlePkg::NUM_PLATS],
    output doodlePkg::platCoordT platY [doodlePkg::NUM_PLATS]
);
    import doodlePkg::*;

    platCoordT placedX;
    logic yClear;

    // keep new platforms away from the left edge
    always_comb
    begin
        if (rawX <= PLACE_LIMIT)
        begin
            placedX = rawX + PLACE_OFFSET;
        end
        else
        begin
            placedX = rawX;
        end
    end

    // ------------------------------------------------------------
    // position registers
    always_ff @(posedge frame_clk or posedge loadplat)
    begin
        if (loadplat)
        begin
            for (int i = 0; i < NUM_PLATS; i++)
            begin
                platX[i] <= PLAT_X_RESET;
                platY[i] <= platCoordT'(PLAT_Y_STEP * (i + 1));
            end
        end
        else
        begin
            case (gameState)
                MENU:
                begin
                    // reroll, one fresh X per frame enters at index 0
                    platX[0] <= placedX;
                    for (int i = 1; i < NUM_PLATS; i++)
                    begin
                        platX[i] <= platX[i - 1];
                    end
                    for (int i = 0; i < NUM_PLATS; i++)
                    begin
                        platY[i] <= '0;
                    end
                end
                GAME:
                begin
                    // scroll upward, wraps modulo 512
                    for (int i = 0; i < NUM_PLATS; i++)
                    begin
                        platY[i] <= platY[i] - scrollY;
                    end
                end
                default:
                begin
                end
            endcase
        end
    end

    always_comb
    begin
        yClear = 1'b1;
        for (int i = 0; i < NUM_PLATS; i++)
        begin
            yClear = yClear && (platY[i] == '0);
        end
    end

    menuClearsY: assert property (
        @(posedge frame_clk) disable iff (loadplat)
        gameState == MENU |=> yClear
    ) else $error("platform Y not cleared after a menu frame");

endmodule

// ==== src/spriteMask.sv ====
// ------------------------------------------------------------
// box tests are inclusive on both edges; bars only in MENU,
// field platforms only outside MENU
// ------------------------------------------------------------
module spriteMask
(
    input  doodlePkg::coordT      drawX,
    input  doodlePkg::coordT      drawY,
    input  doodlePkg::coordT      doodleX,
    input  doodlePkg::coordT      doodleY,
    input  doodlePkg::coordT      doodleSize,
    input  doodlePkg::coordT      cannonX [doodlePkg::NUM_CANNONS],
    input  doodlePkg::coordT      cannonY [doodlePkg::NUM_CANNONS],
    input  doodlePkg::coordT      cannonSize,
    input  doodlePkg::gameStateT  gameState,
    input  doodlePkg::difficultyT difficulty,
    input  doodlePkg::platCoordT  platX [doodlePkg::NUM_PLATS],
    input  doodlePkg::platCoordT  platY [doodlePkg::NUM_PLATS],
    output logic                  doodleHit,
    output logic [2:0]            barHit,
    output logic                  platHit,
    output logic [doodlePkg::NUM_CANNONS-1:0] cannonHit
);
    import doodlePkg::*;

    coordT platHalfW;
    logic [NUM_PLATS-1:0] platHitEach;
    logic inMenu;

    // signed and two bits wider, so the distance never wraps
    function automatic logic boxHit(
        input coordT px,
        input coordT py,
        input coordT cx,
        input coordT cy,
        input coordT hx,
        input coordT hy
    );
        logic signed [11:0] dx;
        logic signed [11:0] dy;
        dx = $signed({2'b00, px}) - $signed({2'b00, cx});
        dy = $signed({2'b00, py}) - $signed({2'b00, cy});
        if (dx < 0)
            dx = -dx;
        if (dy < 0)
            dy = -dy;
        return (dx <= $signed({2'b00, hx})) && (dy <= $signed({2'b00, hy}));
    endfunction

    always_comb
    begin
        case (difficulty)
            EASY:    platHalfW = PLAT_HALF_EASY;
            MEDIUM:  platHalfW = PLAT_HALF_MEDIUM;
            default: platHalfW = PLAT_HALF_HARD;
        endcase
    end

    assign inMenu = (gameState == MENU);

    assign doodleHit = boxHit(drawX, drawY, doodleX, doodleY, doodleSize, doodleSize);

    // ------------------------------------------------------------
    // difficulty selector bars
    assign barHit[0] = inMenu
        && boxHit(drawX, drawY, MENU_BAR_X_EASY, MENU_BAR_Y, platHalfW, PLAT_HALF_H);
    assign barHit[1] = inMenu
        && boxHit(drawX, drawY, MENU_BAR_X_MEDIUM, MENU_BAR_Y, platHalfW, PLAT_HALF_H);
    assign barHit[2] = inMenu
        && boxHit(drawX, drawY, MENU_BAR_X_HARD, MENU_BAR_Y, platHalfW, PLAT_HALF_H);

    // field platforms, centres widened to screen width
    always_comb
    begin
        for (int i = 0; i < NUM_PLATS; i++)
        begin
            platHitEach[i] = boxHit(drawX, drawY, {1'b0, platX[i]}, {1'b0, platY[i]},
                                    platHalfW, PLAT_HALF_H);
        end
    end

    assign platHit = !inMenu && (|platHitEach);

    always_comb
    begin
        for (int c = 0; c < NUM_CANNONS; c++)
        begin
            cannonHit[c] = boxHit(drawX, drawY, cannonX[c], cannonY[c],
                                  cannonSize, cannonSize);
        end
    end

endmodule

// ==== src/colorPriority.sv ====
// ------------------------------------------------------------
// fixed order: doodle, bars, platform, cannons, background
// ------------------------------------------------------------
module colorPriority
(
    input  logic                 doodleHit,
    input  logic [2:0]           barHit,
    input  logic                 platHit,
    input  logic [doodlePkg::NUM_CANNONS-1:0] cannonHit,
    input  doodlePkg::gameStateT gameState,
    output doodlePkg::colorT     red,
    output doodlePkg::colorT     green,
    output doodlePkg::colorT     blue
);
    import doodlePkg::*;

    colorT rgb [3];

    always_comb
    begin
        if (doodleHit)
            rgb = COL_DOODLE;
        else if (barHit[0])
            rgb = COL_EASY;
        else if (barHit[1])
            rgb = COL_MEDIUM;
        else if (barHit[2])
            rgb = COL_HARD;
        else if (platHit)
            rgb = COL_PLAT;
        else if (cannonHit[0])
            rgb = COL_CANNON0;
        else if (cannonHit[1])
            rgb = COL_CANNON1;
        else if (cannonHit[2])
            rgb = COL_CANNON2;
        else if (gameState == MENU)
            rgb = COL_MENU_BG;
        else
            rgb = COL_GAME_BG;
    end

    assign red = rgb[0];
    assign green = rgb[1];
    assign blue = rgb[2];

endmodule

// ==== src/doodleMapper.sv ====
// ------------------------------------------------------------
// colour is combinational from the draw position; platform
// positions change one frame_clk edge after the state is seen
// ------------------------------------------------------------
module doodleMapper
(
    input  logic                  frame_clk,
    input  logic                  loadplat,
    input  doodlePkg::gameStateT  gameState,
    input  doodlePkg::difficultyT difficulty,
    input  doodlePkg::platCoordT  scrollY,
    input  doodlePkg::coordT      drawX,
    input  doodlePkg::coordT      drawY,
    input  doodlePkg::coordT      doodleX,
    input  doodlePkg::coordT      doodleY,
    input  doodlePkg::coordT      doodleSize,
    input  doodlePkg::coordT      cannonX [doodlePkg::NUM_CANNONS],
    input  doodlePkg::coordT      cannonY [doodlePkg::NUM_CANNONS],
    input  doodlePkg::coordT      cannonSize,
    output doodlePkg::colorT      red,
    output doodlePkg::colorT      green,
    output doodlePkg::colorT      blue,
    output doodlePkg::platCoordT  platX [doodlePkg::NUM_PLATS],
    output doodlePkg::platCoordT  platY [doodlePkg::NUM_PLATS]
);
    import doodlePkg::*;

    platCoordT rawX;
    logic doodleHit;
    logic [2:0] barHit;
    logic platHit;
    logic [NUM_CANNONS-1:0] cannonHit;

    platformRng platformRng_i
    (
        .frame_clk (frame_clk),
        .loadplat  (loadplat),
        .rawX      (rawX)
    );

    platformField platformField_i
    (
        .frame_clk (frame_clk),
        .loadplat  (loadplat),
        .gameState (gameState),
        .scrollY   (scrollY),
        .rawX      (rawX),
        .platX     (platX),
        .platY     (platY)
    );

    spriteMask spriteMask_i
    (
        .drawX      (drawX),
        .drawY      (drawY),
        .doodleX    (doodleX),
        .doodleY    (doodleY),
        .doodleSize (doodleSize),
        .cannonX    (cannonX),
        .cannonY    (cannonY),
        .cannonSize (cannonSize),
        .gameState  (gameState),
        .difficulty (difficulty),
        .platX      (platX),
        .platY      (platY),
        .doodleHit  (doodleHit),
        .barHit     (barHit),
        .platHit    (platHit),
        .cannonHit  (cannonHit)
    );

    colorPriority colorPriority_i
    (
        .doodleHit (doodleHit),
        .barHit    (barHit),
        .platHit   (platHit),
        .cannonHit (cannonHit),
        .gameState (gameState),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

endmodule

// ==== tests/mapperModel.svh ====
// ------------------------------------------------------------
// reference model, included inside the testbench module body
// expects the doodlePkg import and the DUT input signals in scope
// ------------------------------------------------------------
`ifndef MAPPER_MODEL_SVH
`define MAPPER_MODEL_SVH

platCoordT refRng;
platCoordT refX [NUM_PLATS];
platCoordT refY [NUM_PLATS];

function automatic void loadStartLayout();
    refRng = 9'h1A5;
    for (int i = 0; i < NUM_PLATS; i++)
    begin
        refX[i] = 9'd240;
        refY[i] = platCoordT'(30 * (i + 1));
    end
endfunction

// x^9 + x^5 + 1, feedback taken from bits 8 and 4
function automatic platCoordT nextLfsr(platCoordT v);
    return platCoordT'((v << 1) | platCoordT'(v[8] ^ v[4]));
endfunction

function automatic platCoordT placeX(platCoordT raw);
    if (raw > 9'd400)
        return raw;
    return raw + 9'd100;
endfunction

// one rising edge of frame_clk
function automatic void advanceFrame(gameStateT st, platCoordT scroll);
    if (st == MENU)
    begin
        for (int i = NUM_PLATS - 1; i > 0; i--)
            refX[i] = refX[i - 1];
        refX[0] = placeX(refRng);
        for (int i = 0; i < NUM_PLATS; i++)
            refY[i] = '0;
    end
    else if (st == GAME)
    begin
        for (int i = 0; i < NUM_PLATS; i++)
            refY[i] = refY[i] - scroll;
    end
    refRng = nextLfsr(refRng);
endfunction

function automatic int halfWidth(difficultyT d);
    case (d)
        EASY:    return 32;
        MEDIUM:  return 16;
        default: return 8;
    endcase
endfunction

function automatic logic inBox(int px, int py, int cx, int cy, int hx, int hy);
    return (px >= cx - hx) && (px <= cx + hx) && (py >= cy - hy) && (py <= cy + hy);
endfunction

`endif

// ==== tests/doodleMapperTb.sv ====
// ------------------------------------------------------------
// random frames from seed 39; inputs change on the falling edge
// ------------------------------------------------------------
module doodleMapperTb;
    import doodlePkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int MENU_MAX = 40;
    localparam int GAME_FRAMES = 80;
    localparam int TOTAL_CYCLES = RESET_CYCLES + MENU_MAX + GAME_FRAMES + 1;

    logic frame_clk;
    logic loadplat;
    gameStateT gameState;
    difficultyT difficulty;
    platCoordT scrollY;
    coordT drawX;
    coordT drawY;
    coordT doodleX;
    coordT doodleY;
    coordT doodleSize;
    coordT cannonX [NUM_CANNONS];
    coordT cannonY [NUM_CANNONS];
    coordT cannonSize;
    colorT red;
    colorT green;
    colorT blue;
    platCoordT platX [NUM_PLATS];
    platCoordT platY [NUM_PLATS];

    int seed = 39;
    int platErrors = 0;
    int colorErrors = 0;

    `include "mapperModel.svh"

    doodleMapper doodleMapper_i
    (
        .frame_clk  (frame_clk),
        .loadplat   (loadplat),
        .gameState  (gameState),
        .difficulty (difficulty),
        .scrollY    (scrollY),
        .drawX      (drawX),
        .drawY      (drawY),
        .doodleX    (doodleX),
        .doodleY    (doodleY),
        .doodleSize (doodleSize),
        .cannonX    (cannonX),
        .cannonY    (cannonY),
        .cannonSize (cannonSize),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .platX      (platX),
        .platY      (platY)
    );

    // priority: doodle, bars, platform, cannons, background
    function automatic void predictColor(output colorT r, output colorT g, output colorT b);
        colorT col [3];
        int px;
        int py;
        int hw;
        logic menu;
        logic onPlat;
        px = drawX;
        py = drawY;
        hw = halfWidth(difficulty);
        menu = (gameState == MENU);
        onPlat = 1'b0;
        for (int i = 0; i < NUM_PLATS; i++)
            if (inBox(px, py, refX[i], refY[i], hw, 4))
                onPlat = 1'b1;
        if (inBox(px, py, doodleX, doodleY, doodleSize, doodleSize))
            col = COL_DOODLE;
        else if (menu && inBox(px, py, 230, 200, hw, 4))
            col = COL_EASY;
        else if (menu && inBox(px, py, 330, 200, hw, 4))
            col = COL_MEDIUM;
        else if (menu && inBox(px, py, 430, 200, hw, 4))
            col = COL_HARD;
        else if (!menu && onPlat)
            col = COL_PLAT;
        else if (inBox(px, py, cannonX[0], cannonY[0], cannonSize, cannonSize))
            col = COL_CANNON0;
        else if (inBox(px, py, cannonX[1], cannonY[1], cannonSize, cannonSize))
            col = COL_CANNON1;
        else if (inBox(px, py, cannonX[2], cannonY[2], cannonSize, cannonSize))
            col = COL_CANNON2;
        else if (menu)
            col = COL_MENU_BG;
        else
            col = COL_GAME_BG;
        r = col[0];
        g = col[1];
        b = col[2];
    endfunction

    function automatic int randRange(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic checkPlat(string name, platCoordT expected, platCoordT actual);
        if (expected !== actual)
        begin
            $display("FAILED %s expected %0d actual %0d", name, expected, actual);
            platErrors++;
        end
    endtask

    task automatic checkColor(string name, colorT expR, colorT expG, colorT expB,
                              colorT actR, colorT actG, colorT actB);
        if (expR !== actR || expG !== actG || expB !== actB)
        begin
            $display("FAILED %s expected %02h/%02h/%02h actual %02h/%02h/%02h",
                     name, expR, expG, expB, actR, actG, actB);
            colorErrors++;
        end
    endtask

    task automatic checkPositions(string tag);
        for (int i = 0; i < NUM_PLATS; i++)
        begin
            checkPlat($sformatf("%s platX[%0d]", tag, i), refX[i], platX[i]);
            checkPlat($sformatf("%s platY[%0d]", tag, i), refY[i], platY[i]);
        end
    endtask

    // aim the pixel near some object so that hits are frequent
    task automatic pickDrawPoint();
        int kind;
        int k;
        int cx;
        int cy;
        kind = randRange(5);
        k = randRange(NUM_PLATS);
        case (kind)
            0:
            begin
                cx = doodleX;
                cy = doodleY;
            end
            1:
            begin
                cx = cannonX[k % NUM_CANNONS];
                cy = cannonY[k % NUM_CANNONS];
            end
            2:
            begin
                cx = refX[k];
                cy = refY[k];
            end
            3:
            begin
                cx = 230 + 100 * (k % 3);
                cy = 200;
            end
            default:
            begin
                cx = randRange(640);
                cy = randRange(480);
            end
        endcase
        drawX = coordT'(cx + randRange(81) - 40);
        drawY = coordT'(cy + randRange(17) - 8);
    endtask

    // called on a falling edge, returns on the next one
    task automatic runFrame(string tag, gameStateT st);
        colorT er;
        colorT eg;
        colorT eb;
        checkPositions(tag);
        gameState = st;
        scrollY = platCoordT'(randRange(512));
        difficulty = difficultyT'(2'(randRange(4)));
        pickDrawPoint();
        #2;
        predictColor(er, eg, eb);
        checkColor({tag, " colour"}, er, eg, eb, red, green, blue);
        @(posedge frame_clk);
        advanceFrame(st, scrollY);
        @(negedge frame_clk);
    endtask

    initial
    begin
        frame_clk = 1'b0;
        forever #4 frame_clk = ~frame_clk;
    end

    initial
    begin
        #((TOTAL_CYCLES + 50) * 8);
        $display("timeout: the test sequence did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        int numMenu;
        loadplat = 1'b1;
        gameState = MENU;
        difficulty = EASY;
        scrollY = '0;
        drawX = '0;
        drawY = '0;
        doodleX = 10'd1000;
        doodleY = 10'd1000;
        doodleSize = 10'd2;
        cannonSize = 10'd2;
        for (int c = 0; c < NUM_CANNONS; c++)
        begin
            cannonX[c] = 10'd1000;
            cannonY[c] = 10'd1000;
        end
        loadStartLayout();
        repeat (RESET_CYCLES) @(posedge frame_clk);
        @(negedge frame_clk);
        loadplat = 1'b0;
        checkPositions("reset");

        // menu with sprites parked off screen, bars fully visible
        numMenu = 10 + randRange(MENU_MAX - 10);
        for (int f = 0; f < numMenu; f++)
            runFrame($sformatf("menu frame %0d", f), MENU);

        // ------------------------------------------------------------
        // play, with pause frames mixed in
        for (int f = 0; f < GAME_FRAMES; f++)
        begin
            doodleX = coordT'(randRange(640));
            doodleY = coordT'(randRange(480));
            doodleSize = coordT'(randRange(16));
            cannonSize = coordT'(randRange(12));
            for (int c = 0; c < NUM_CANNONS; c++)
            begin
                cannonX[c] = coordT'(randRange(640));
                cannonY[c] = coordT'(randRange(480));
            end
            if (randRange(4) == 0)
                runFrame($sformatf("pause frame %0d", f), PAUSE);
            else
                runFrame($sformatf("game frame %0d", f), GAME);
        end
        checkPositions("final");

        $display("errors: %0d position, %0d colour", platErrors, colorErrors);
        if (platErrors + colorErrors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== doodleMapper.f ====
+incdir+tests
src/doodlePkg.sv
src/platformRng.sv
src/platformField.sv
src/spriteMask.sv
src/colorPriority.sv
src/doodleMapper.sv
tests/doodleMapperTb.sv

// ==== Makefile ====
# Verilator build and run for the doodleMapper testbench

VERILATOR ?= verilator
TOP       ?= doodleMapperTb
FILELIST  ?= doodleMapper.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(wildcard src/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# pass only when the pass line shows up in the output
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJDIR)
